//--- common/dcache_pkg.sv
package dcache_pkg;
    // address layout, low field first
    localparam int WORD_W  = 32;
    localparam int BYT_W   = 2;
    localparam int BLK_W   = 1;
    localparam int IDX_W   = 3;
    localparam int TAG_W   = WORD_W - IDX_W - BLK_W - BYT_W;

    localparam int BLK_LSB = BYT_W;
    localparam int IDX_LSB = BLK_LSB + BLK_W;
    localparam int TAG_LSB = IDX_LSB + IDX_W;

    // geometry
    localparam int NUM_SETS   = 8;
    localparam int BLK_WORDS  = 2;
    localparam int NUM_FRAMES = 16;  // both ways, all sets

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [IDX_W-1:0]  idx_t;

    // miss handling, write-back then fill
    typedef enum logic [2:0] {
        M_IDLE,
        M_WB1,
        M_WB2,
        M_LD1,
        M_LD2
    } miss_state_t;

    // flush walk on halt
    typedef enum logic [2:0] {
        F_IDLE,
        F_SCAN,
        F_WR1,
        F_WR2,
        F_DONE
    } flush_state_t;
endpackage

//--- common/mem_bus_if.sv
interface mem_bus_if;
    import dcache_pkg::*;

    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
    word_t load;
    logic  dwait;  // high until the transfer is taken

    modport master (
        output ren,
        output wen,
        output addr,
        output store,
        input  load,
        input  dwait
    );

    modport slave (
        input  ren,
        input  wen,
        input  addr,
        input  store,
        output load,
        output dwait
    );
endinterface

//--- common/frame_if.sv
interface frame_if;
    import dcache_pkg::*;

    // LRU way of the requested set
    tag_t                  victim_tag;
    word_t [BLK_WORDS-1:0] victim_data;
    logic                  victim_dirty;

    // frame picked by the flush walk
    logic                  sel_way;
    idx_t                  sel_idx;
    tag_t                  frame_tag;
    word_t [BLK_WORDS-1:0] frame_data;
    logic                  frame_dirty;

    // one fill word per cycle, tag and set come from the request
    logic                  fill_en;
    logic [BLK_W-1:0]      fill_word;
    word_t                 fill_data;

    modport store (
        output victim_tag, victim_data, victim_dirty,
        output frame_tag, frame_data, frame_dirty,
        input  sel_way, sel_idx,
        input  fill_en, fill_word, fill_data
    );

    modport miss (
        input  victim_tag, victim_data, victim_dirty,
        output fill_en, fill_word, fill_data
    );

    modport flush (
        input  frame_tag, frame_data, frame_dirty,
        output sel_way, sel_idx
    );
endinterface

//--- hw/dcache/dcache_ways.sv
module dcache_ways (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  logic              miss_busy,
    input  logic              flush_busy,
    output dcache_pkg::word_t dmem_load,
    output logic              dhit,
    output logic              miss,
    frame_if.store            miss_fi,
    frame_if.store            flush_fi
);
    import dcache_pkg::*;

    // storage indexed [way][set]
    logic [1:0][NUM_SETS-1:0] valid;
    logic [1:0][NUM_SETS-1:0] dirty;
    logic [NUM_SETS-1:0]      lru;  // way to replace next
    tag_t                     tags [2][NUM_SETS];
    word_t [BLK_WORDS-1:0]    data [2][NUM_SETS];

    tag_t             a_tag;
    idx_t             a_idx;
    logic [BLK_W-1:0] a_blk;
    logic             lookup;
    logic             hit0;
    logic             hit1;
    logic             hit_way;
    logic             vway;
    logic             wr_hit;
    logic             fill_last;

    assign a_tag = dmem_addr[TAG_LSB +: TAG_W];
    assign a_idx = dmem_addr[IDX_LSB +: IDX_W];
    assign a_blk = dmem_addr[BLK_LSB +: BLK_W];

    // no lookups while an engine owns the arrays
    assign lookup  = (dmem_ren || dmem_wen) && !miss_busy && !flush_busy;
    assign hit0    = valid[0][a_idx] && (tags[0][a_idx] == a_tag);
    assign hit1    = valid[1][a_idx] && (tags[1][a_idx] == a_tag);
    assign hit_way = !hit0;  // way 1 only if way 0 misses
    assign dhit    = lookup && (hit0 || hit1);
    assign miss    = lookup && !(hit0 || hit1);
    assign wr_hit  = dhit && dmem_wen;

    assign dmem_load = data[hit_way][a_idx][a_blk];

    assign vway      = lru[a_idx];
    assign fill_last = miss_fi.fill_en && (miss_fi.fill_word == BLK_W'(BLK_WORDS - 1));

    // victim offered to the miss engine
    assign miss_fi.victim_tag   = tags[vway][a_idx];
    assign miss_fi.victim_data  = data[vway][a_idx];
    assign miss_fi.victim_dirty = valid[vway][a_idx] && dirty[vway][a_idx];

    // frame picked by the flush engine
    assign flush_fi.frame_tag   = tags[flush_fi.sel_way][flush_fi.sel_idx];
    assign flush_fi.frame_data  = data[flush_fi.sel_way][flush_fi.sel_idx];
    assign flush_fi.frame_dirty = valid[flush_fi.sel_way][flush_fi.sel_idx]
                                && dirty[flush_fi.sel_way][flush_fi.sel_idx];

    // each port only carries its own half
    assign miss_fi.frame_tag     = '0;
    assign miss_fi.frame_data    = '0;
    assign miss_fi.frame_dirty   = 1'b0;
    assign flush_fi.victim_tag   = '0;
    assign flush_fi.victim_data  = '0;
    assign flush_fi.victim_dirty = 1'b0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (dhit) begin
                lru[a_idx] <= ~hit_way;  // point at the other way
                if (dmem_wen) begin
                    dirty[hit_way][a_idx] <= 1'b1;
                end
            end
            if (fill_last) begin
                valid[vway][a_idx] <= 1'b1;
                dirty[vway][a_idx] <= 1'b0;
                lru[a_idx]         <= ~vway;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_hit) begin
            data[hit_way][a_idx][a_blk] <= dmem_store;
        end
        if (miss_fi.fill_en) begin
            data[vway][a_idx][miss_fi.fill_word] <= miss_fi.fill_data;
        end
        // tag goes in with the last word
        if (fill_last) begin
            tags[vway][a_idx] <= a_tag;
        end
    end
endmodule

//--- hw/dcache/miss_engine.sv
module miss_engine (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              miss,
    input  dcache_pkg::word_t dmem_addr,
    output logic              miss_busy,
    frame_if.miss             fi,
    mem_bus_if.master         bus
);
    import dcache_pkg::*;

    miss_state_t      state;
    miss_state_t      next_state;
    logic [BLK_W-1:0] wsel;  // word of the block on the bus
    tag_t             req_tag;
    idx_t             req_idx;

    assign req_tag   = dmem_addr[TAG_LSB +: TAG_W];
    assign req_idx   = dmem_addr[IDX_LSB +: IDX_W];
    assign wsel      = BLK_W'(state == M_WB2 || state == M_LD2);
    assign miss_busy = (state != M_IDLE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= M_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // every bus state waits for dwait low
    always_comb begin
        next_state = state;
        case (state)
            M_IDLE: begin
                if (miss) begin
                    next_state = fi.victim_dirty ? M_WB1 : M_LD1;
                end
            end
            M_WB1: begin
                if (!bus.dwait) begin
                    next_state = M_WB2;
                end
            end
            M_WB2: begin
                if (!bus.dwait) begin
                    next_state = M_LD1;
                end
            end
            M_LD1: begin
                if (!bus.dwait) begin
                    next_state = M_LD2;
                end
            end
            M_LD2: begin
                if (!bus.dwait) begin
                    next_state = M_IDLE;
                end
            end
            default: next_state = M_IDLE;
        endcase
    end

    always_comb begin
        bus.ren    = 1'b0;
        bus.wen    = 1'b0;
        bus.addr   = {req_tag, req_idx, wsel, {BYT_W{1'b0}}};
        bus.store  = fi.victim_data[wsel];
        fi.fill_en = 1'b0;
        case (state)
            M_WB1, M_WB2: begin
                bus.wen  = 1'b1;
                bus.addr = {fi.victim_tag, req_idx, wsel, {BYT_W{1'b0}}};  // victim block
            end
            M_LD1, M_LD2: begin
                bus.ren    = 1'b1;
                fi.fill_en = !bus.dwait;  // write the word as it arrives
            end
            default: ;
        endcase
    end

    assign fi.fill_word = wsel;
    assign fi.fill_data = bus.load;
endmodule

//--- hw/dcache/flush_engine.sv
module flush_engine (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      halt,
    input  logic      miss_busy,
    output logic      flush_busy,
    output logic      flushed,
    frame_if.flush    fi,
    mem_bus_if.master bus
);
    import dcache_pkg::*;

    flush_state_t     state;
    flush_state_t     next_state;
    logic [4:0]       frame_cnt;  // way in bit 3, set below
    logic [4:0]       next_cnt;
    logic [BLK_W-1:0] wsel;
    logic             walk_end;

    assign fi.sel_way = frame_cnt[IDX_W];
    assign fi.sel_idx = frame_cnt[IDX_W-1:0];
    assign walk_end   = (frame_cnt == 5'(NUM_FRAMES));
    assign wsel       = BLK_W'(state == F_WR2);
    assign flush_busy = (state != F_IDLE);
    assign flushed    = (state == F_DONE);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= F_IDLE;
            frame_cnt <= '0;
        end else begin
            state     <= next_state;
            frame_cnt <= next_cnt;
        end
    end

    always_comb begin
        next_state = state;
        next_cnt   = frame_cnt;
        case (state)
            F_IDLE: begin
                if (halt && !miss_busy) begin
                    next_state = F_SCAN;
                    next_cnt   = '0;
                end
            end
            F_SCAN: begin
                if (walk_end) begin
                    next_state = F_DONE;
                end else if (fi.frame_dirty) begin
                    next_state = F_WR1;
                end else begin
                    next_cnt = frame_cnt + 5'd1;  // clean frame, skip
                end
            end
            F_WR1: begin
                if (!bus.dwait) begin
                    next_state = F_WR2;
                end
            end
            F_WR2: begin
                if (!bus.dwait) begin
                    next_state = F_SCAN;
                    next_cnt   = frame_cnt + 5'd1;
                end
            end
            default: ;  // F_DONE holds until reset
        endcase
    end

    // write-only master, load is never used
    assign bus.ren   = 1'b0;
    assign bus.wen   = (state == F_WR1) || (state == F_WR2);
    assign bus.addr  = {fi.frame_tag, fi.sel_idx, wsel, {BYT_W{1'b0}}};
    assign bus.store = fi.frame_data[wsel];
endmodule

//--- hw/mem_arbiter.sv
module mem_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  dcache_pkg::word_t mem_load,
    input  logic              mem_wait,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    mem_bus_if.slave          miss_bus,
    mem_bus_if.slave          flush_bus
);
    logic miss_req;
    logic flush_req;
    logic owner_vld;  // a transfer is in flight
    logic owner;      // 0 miss engine, 1 flush engine
    logic gnt;
    logic active;

    assign miss_req  = miss_bus.ren || miss_bus.wen;
    assign flush_req = flush_bus.ren || flush_bus.wen;

    // miss engine wins when nobody holds the port
    assign gnt    = owner_vld ? owner : !miss_req;
    assign active = owner_vld || miss_req || flush_req;

    assign mem_ren   = gnt ? flush_bus.ren   : miss_bus.ren;
    assign mem_wen   = gnt ? flush_bus.wen   : miss_bus.wen;
    assign mem_addr  = gnt ? flush_bus.addr  : miss_bus.addr;
    assign mem_store = gnt ? flush_bus.store : miss_bus.store;

    // loser sees wait high
    assign miss_bus.load   = gnt ? '0 : mem_load;
    assign miss_bus.dwait  = gnt ? 1'b1 : mem_wait;
    assign flush_bus.load  = gnt ? mem_load : '0;
    assign flush_bus.dwait = gnt ? mem_wait : 1'b1;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            owner_vld <= 1'b0;
            owner     <= 1'b0;
        end else begin
            owner_vld <= active && mem_wait;  // released on completion
            owner     <= gnt;
        end
    end
endmodule

//--- hw/dcache/dcache.sv
module dcache (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    output dcache_pkg::word_t dmem_load,
    output logic              dhit,
    input  logic              halt,
    output logic              flushed,
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  dcache_pkg::word_t mem_load,
    input  logic              mem_wait
);
    logic miss;
    logic miss_busy;
    logic flush_busy;

    frame_if   miss_fi ();
    frame_if   flush_fi ();
    mem_bus_if miss_bus ();
    mem_bus_if flush_bus ();

    dcache_ways ways0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .miss_busy  (miss_busy),
        .flush_busy (flush_busy),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .miss       (miss),
        .miss_fi    (miss_fi),
        .flush_fi   (flush_fi)
    );

    miss_engine miss0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .miss      (miss),
        .dmem_addr (dmem_addr),
        .miss_busy (miss_busy),
        .fi        (miss_fi),
        .bus       (miss_bus)
    );

    flush_engine flush0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .halt       (halt),
        .miss_busy  (miss_busy),
        .flush_busy (flush_busy),
        .flushed    (flushed),
        .fi         (flush_fi),
        .bus        (flush_bus)
    );

    mem_arbiter arb0 (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_load  (mem_load),
        .mem_wait  (mem_wait),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_store (mem_store),
        .miss_bus  (miss_bus),
        .flush_bus (flush_bus)
    );
endmodule

//--- verification/mem_model.sv
module mem_model #(
    parameter int WAIT_CYCLES = 2,
    parameter int ADDR_BITS   = 10
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] addr,
    input  logic [31:0] store,
    output logic [31:0] load,
    output logic        mem_wait
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]          words [2**ADDR_BITS];  // filled by the testbench at time 0
    logic [ADDR_BITS-1:0] idx;
    logic                 busy;
    int                   cnt;  // wait cycles spent on this transfer

    assign idx      = addr[ADDR_BITS+1:2];
    assign busy     = ren || wen;
    assign mem_wait = busy && (cnt < WAIT_CYCLES);
    assign load     = ren ? words[idx] : '0;

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= 0;
        end else if (mem_wait) begin
            cnt <= cnt + 1;
        end else begin
            cnt <= 0;  // transfer done or no request
        end
    end

    always @(posedge CLK) begin
        if (wen && !mem_wait) begin
            words[idx] <= store;
        end
    end
endmodule

//--- verification/tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 8;
    localparam logic [31:0] SEED         = 32'ha7cb;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    localparam int          MEM_WAIT     = 2;
    localparam int          MEM_BITS     = 10;  // 1024 words
    localparam int          RAND_OPS     = 200;
    localparam int          DIRECTED_OPS = 16;
    // write-back and fill, plus lookup, hit and idle cycles
    localparam int          MISS_CYCLES  = 4 * (MEM_WAIT + 1) + 4;
    localparam int          FLUSH_CYCLES = 16 * (1 + 2 * (MEM_WAIT + 1)) + 2;
    localparam int          TIMEOUT      =
        2 * ((DIRECTED_OPS + RAND_OPS) * MISS_CYCLES + 2 * FLUSH_CYCLES) + 20;

    logic        CLK;
    logic        nRST;
    logic        dmem_ren;
    logic        dmem_wen;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_store;
    logic [31:0] dmem_load;
    logic        dhit;
    logic        halt;
    logic        flushed;
    logic        mem_ren;
    logic        mem_wen;
    logic [31:0] mem_addr;
    logic [31:0] mem_store;
    logic [31:0] mem_load;
    logic        mem_wait;

    logic [31:0] shadow [2**MEM_BITS];
    logic        written [2**MEM_BITS];
    logic [31:0] lfsr;
    logic        hit_now;  // dhit at the last sample point
    int          last_wait;
    int          checks;
    int          errors;
    int          errors_mark;
    int          test_num;
    int          cycles;
    event        sampled;

    dcache dut0 (
        .CLK        (CLK),
        .nRST       (nRST),
        .dmem_ren   (dmem_ren),
        .dmem_wen   (dmem_wen),
        .dmem_addr  (dmem_addr),
        .dmem_store (dmem_store),
        .dmem_load  (dmem_load),
        .dhit       (dhit),
        .halt       (halt),
        .flushed    (flushed),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_store  (mem_store),
        .mem_load   (mem_load),
        .mem_wait   (mem_wait)
    );

    mem_model #(
        .WAIT_CYCLES (MEM_WAIT),
        .ADDR_BITS   (MEM_BITS)
    ) mem0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .ren      (mem_ren),
        .wen      (mem_wen),
        .addr     (mem_addr),
        .store    (mem_store),
        .load     (mem_load),
        .mem_wait (mem_wait)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] init_pattern(input logic [31:0] a);
        return (a * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
    endfunction

    // last stored value, else what memory started with
    function automatic logic [31:0] expected_load(input logic [31:0] a);
        if (written[a[MEM_BITS+1:2]]) begin
            return shadow[a[MEM_BITS+1:2]];
        end
        return init_pattern(a);
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    // sample a quarter period after the drive edge
    always begin : compare_loads
        logic [31:0] expected;
        @(negedge CLK);
        #(CLK_PERIOD / 4);
        hit_now = dhit;
        if (dhit && dmem_ren) begin
            expected = expected_load(dmem_addr);
            checks++;
            assert (dmem_load === expected) else begin
                errors++;
                $display("Error at %0d ns: load of %h returned %h, expected %h",
                         $time, dmem_addr, dmem_load, expected);
            end
        end
        -> sampled;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, a request or the flush never finished", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic reset_dut();
        nRST     = 1'b0;
        halt     = 1'b0;
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
        repeat (3) @(negedge CLK);
        nRST = 1'b1;
    endtask

    // nothing pending right after reset
    task automatic check_idle();
        @(sampled);
        checks++;
        assert ({dhit, flushed, mem_ren, mem_wen} === 4'b0000) else begin
            errors++;
            $display("Error at %0d ns: dhit %b flushed %b mem_ren %b mem_wen %b, expected all low",
                     $time, dhit, flushed, mem_ren, mem_wen);
        end
    endtask

    // hold the request until dhit, then release it
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data);
        @(negedge CLK);
        dmem_ren   = !wr;
        dmem_wen   = wr;
        dmem_addr  = addr;
        dmem_store = data;
        last_wait  = 0;
        @(sampled);
        while (!hit_now) begin
            last_wait++;
            @(sampled);
        end
        if (wr) begin
            shadow[addr[MEM_BITS+1:2]]  = data;
            written[addr[MEM_BITS+1:2]] = 1'b1;
        end
        @(negedge CLK);
        dmem_ren = 1'b0;
        dmem_wen = 1'b0;
    endtask

    task automatic check_latency(input logic [31:0] addr, input logic want_hit);
        checks++;
        assert ((last_wait == 0) == want_hit) else begin
            errors++;
            $display("access to %h at %0d ns %s", addr, $time,
                     want_hit ? "missed where a hit was due" : "hit on a block never loaded");
        end
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        logic        wr;
        take_bits(1, r);
        wr = r[0];
        take_bits(6, r);
        // 16 tags over sets 0 and 1
        addr = 32'h800 | (32'(r[5:2]) << 6) | (32'(r[1]) << 3) | (32'(r[0]) << 2);
        data = '0;
        if (wr) begin
            take_bits(32, data);
        end
        access(wr, addr, data);
    endtask

    task automatic flush_and_wait();
        @(negedge CLK);
        halt = 1'b1;
        @(sampled);
        while (!flushed) begin
            @(sampled);
        end
    endtask

    task automatic compare_memory();
        for (int i = 0; i < 2**MEM_BITS; i++) begin
            checks++;
            assert (mem0.words[i] === expected_load(32'(i) << 2)) else begin
                errors++;
                $display("Error at %0d ns: memory word %h holds %h, expected %h", $time,
                         32'(i) << 2, mem0.words[i], expected_load(32'(i) << 2));
            end
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %s: %s (%0d errors)", test_num, name,
                 (errors == errors_mark) ? "ok" : "failed", errors - errors_mark);
        errors_mark = errors;
    endtask

    initial begin : run_tests
        lfsr        = SEED;
        checks      = 0;
        errors      = 0;
        errors_mark = 0;
        test_num    = 0;
        cycles      = 0;
        dmem_addr   = '0;
        dmem_store  = '0;
        for (int i = 0; i < 2**MEM_BITS; i++) begin
            mem0.words[i] = init_pattern(32'(i) << 2);
            shadow[i]     = '0;
            written[i]    = 1'b0;
        end
        reset_dut();
        check_idle();

        access(1'b0, 32'h100, '0);
        check_latency(32'h100, 1'b0);
        access(1'b0, 32'h100, '0);
        check_latency(32'h100, 1'b1);
        access(1'b0, 32'h104, '0);  // block partner
        check_latency(32'h104, 1'b1);
        report_test("read miss then hits");

        access(1'b1, 32'h200, 32'hdead_beef);
        access(1'b0, 32'h200, '0);
        check_latency(32'h200, 1'b1);
        report_test("store then load");

        // three tags on set 2 but only two ways
        for (int t = 0; t < 3; t++) begin
            access(1'b1, 32'h010 + 32'(t) * 32'h40, 32'h1111_0000 + 32'(t));
        end
        for (int t = 0; t < 3; t++) begin
            access(1'b0, 32'h010 + 32'(t) * 32'h40, '0);
            check_latency(32'h010 + 32'(t) * 32'h40, 1'b0);
        end
        report_test("dirty eviction and refill");

        access(1'b1, 32'h300, 32'hcafe_0001);
        access(1'b1, 32'h30c, 32'hcafe_0002);
        access(1'b1, 32'h708, 32'hcafe_0003);
        access(1'b1, 32'h014, 32'hcafe_0004);
        flush_and_wait();
        compare_memory();
        report_test("flush on halt");

        @(negedge CLK);
        reset_dut();
        check_idle();
        repeat (RAND_OPS) random_op();
        flush_and_wait();
        compare_memory();
        report_test("random loads and stores");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

//--- src.f
common/dcache_pkg.sv
common/mem_bus_if.sv
common/frame_if.sv
hw/dcache/dcache_ways.sv
hw/dcache/miss_engine.sv
hw/dcache/flush_engine.sv
hw/mem_arbiter.sv
hw/dcache/dcache.sv
verification/mem_model.sv
verification/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - common/dcache_pkg.sv
  - common/mem_bus_if.sv
  - common/frame_if.sv
  - hw/dcache/dcache_ways.sv
  - hw/dcache/miss_engine.sv
  - hw/dcache/flush_engine.sv
  - hw/mem_arbiter.sv
  - hw/dcache/dcache.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/tb_dcache.sv
